// File: source/mem_pkg.sv
package mem_pkg;

    // bus widths
    localparam int DATA_W         = 32;
    localparam int DOUBLE_W       = 64;
    localparam int ALUOP_W        = 8;
    localparam int RAM_DEPTH_LOG2 = 10;     // 1024 words

    // memory operations seen by this stage
    typedef enum logic [ALUOP_W-1:0] {
        OP_NOP = 8'b0000_0000,
        OP_LB  = 8'b1110_0000,
        OP_LBU = 8'b1110_0100,
        OP_LH  = 8'b1110_0001,
        OP_LHU = 8'b1110_0101,
        OP_LW  = 8'b1110_0011,
        OP_SB  = 8'b1110_1000,
        OP_SH  = 8'b1110_1001,
        OP_SW  = 8'b1110_1011
    } aluop_t;

    // cp0 register addresses
    localparam logic [4:0] CP0_REG_STATUS = 5'd12;
    localparam logic [4:0] CP0_REG_CAUSE  = 5'd13;
    localparam logic [4:0] CP0_REG_EPC    = 5'd14;

    // bit positions in the incoming flag word
    localparam int EXC_FLAG_SYSCALL = 8;
    localparam int EXC_FLAG_INV     = 9;
    localparam int EXC_FLAG_TRAP    = 10;
    localparam int EXC_FLAG_OV      = 11;
    localparam int EXC_FLAG_ERET    = 12;

    // exception codes
    localparam logic [31:0] EXC_NONE    = 32'h0000_0000;
    localparam logic [31:0] EXC_INT     = 32'h0000_0001;
    localparam logic [31:0] EXC_SYSCALL = 32'h0000_0008;
    localparam logic [31:0] EXC_INV     = 32'h0000_000a;
    localparam logic [31:0] EXC_OV      = 32'h0000_000c;
    localparam logic [31:0] EXC_TRAP    = 32'h0000_000d;
    localparam logic [31:0] EXC_ERET    = 32'h0000_000e;

    // status fields
    localparam int STATUS_IE     = 0;
    localparam int STATUS_EXL    = 1;
    localparam int STATUS_IM_LSB = 8;
    localparam int STATUS_IM_MSB = 15;

    // cause fields
    localparam int CAUSE_IP_LSB = 8;
    localparam int CAUSE_IP_MSB = 15;

endpackage

// File: source/exception_detect.sv
`timescale 1ns/10ps

module exception_detect (
    input  logic                       rst_i,
    input  logic [31:0]                exc_flags_i,
    input  logic [mem_pkg::DATA_W-1:0] cp0_status_i,
    input  logic [mem_pkg::DATA_W-1:0] cp0_cause_i,
    output logic [31:0]                exception_type_o
);

    import mem_pkg::*;

    logic [7:0] int_lines;
    logic       int_enabled;
    logic       int_pending;

    // ip bits that are also unmasked
    assign int_lines = cp0_cause_i[CAUSE_IP_MSB:CAUSE_IP_LSB]
                     & cp0_status_i[STATUS_IM_MSB:STATUS_IM_LSB];

    assign int_enabled = cp0_status_i[STATUS_IE] & ~cp0_status_i[STATUS_EXL];
    assign int_pending = (|int_lines) & int_enabled;

    // fixed priority, interrupt first
    always_comb begin
        exception_type_o = EXC_NONE;
        if (rst_i) begin
            exception_type_o = EXC_NONE;
        end else if (int_pending) begin
            exception_type_o = EXC_INT;
        end else if (exc_flags_i[EXC_FLAG_SYSCALL]) begin
            exception_type_o = EXC_SYSCALL;
        end else if (exc_flags_i[EXC_FLAG_INV]) begin
            exception_type_o = EXC_INV;
        end else if (exc_flags_i[EXC_FLAG_TRAP]) begin
            exception_type_o = EXC_TRAP;
        end else if (exc_flags_i[EXC_FLAG_OV]) begin
            exception_type_o = EXC_OV;
        end else if (exc_flags_i[EXC_FLAG_ERET]) begin
            exception_type_o = EXC_ERET;
        end
    end

endmodule

// File: source/hilo_reg.sv
`timescale 1ns/10ps

module hilo_reg (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [mem_pkg::DATA_W-1:0] new_hi_i,
    input  logic                       w_hi_i,
    input  logic [mem_pkg::DATA_W-1:0] new_lo_i,
    input  logic                       w_lo_i,
    output logic [mem_pkg::DATA_W-1:0] hi_o,
    output logic [mem_pkg::DATA_W-1:0] lo_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            if (w_hi_i) begin
                hi_o <= new_hi_i;
            end
            if (w_lo_i) begin
                lo_o <= new_lo_i;   // independent of hi strobe
            end
        end
    end

endmodule

// File: source/mem_io_controller.sv
`timescale 1ns/10ps

module mem_io_controller (
    input  logic                       rst_i,
    input  mem_pkg::aluop_t            aluop_i,
    input  logic [mem_pkg::DATA_W-1:0] store_data_i,
    input  logic [31:0]                mem_io_addr_i,
    input  logic                       rmem_i,
    input  logic                       wmem_i,
    input  logic [mem_pkg::DATA_W-1:0] ram_rdata_i,
    output logic [31:0]                ram_addr_o,
    output logic [3:0]                 ram_sel_o,
    output logic [mem_pkg::DATA_W-1:0] ram_wdata_o,
    output logic                       ram_we_o,
    output logic                       ram_ce_o,
    output logic [mem_pkg::DATA_W-1:0] read_data_o
);

    import mem_pkg::*;

    logic [1:0]  lane;
    logic [3:0]  byte_sel;
    logic [3:0]  half_sel;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign lane       = mem_io_addr_i[1:0];
    assign ram_addr_o = {mem_io_addr_i[31:2], 2'b00};   // word aligned

    // big endian lanes, offset 0 is the top byte
    always_comb begin
        case (lane)
            2'b00: begin
                byte_sel = 4'b1000;
                rd_byte  = ram_rdata_i[31:24];
            end
            2'b01: begin
                byte_sel = 4'b0100;
                rd_byte  = ram_rdata_i[23:16];
            end
            2'b10: begin
                byte_sel = 4'b0010;
                rd_byte  = ram_rdata_i[15:8];
            end
            default: begin
                byte_sel = 4'b0001;
                rd_byte  = ram_rdata_i[7:0];
            end
        endcase
    end

    // halfword lane from bit 1 only
    assign half_sel = lane[1] ? 4'b0011 : 4'b1100;
    assign rd_half  = lane[1] ? ram_rdata_i[15:0] : ram_rdata_i[31:16];

    // store side
    always_comb begin
        ram_sel_o   = 4'b0000;
        ram_wdata_o = store_data_i;
        case (aluop_i)
            OP_SB: begin
                ram_sel_o   = byte_sel;
                ram_wdata_o = {4{store_data_i[7:0]}};
            end
            OP_SH: begin
                ram_sel_o   = half_sel;
                ram_wdata_o = {2{store_data_i[15:0]}};
            end
            OP_SW: begin
                ram_sel_o   = 4'b1111;
            end
            OP_LB, OP_LBU: begin
                ram_sel_o   = byte_sel;
            end
            OP_LH, OP_LHU: begin
                ram_sel_o   = half_sel;
            end
            OP_LW: begin
                ram_sel_o   = 4'b1111;
            end
            default: begin
                ram_sel_o   = 4'b0000;  // not a memory op
            end
        endcase
    end

    // load side, extend per op
    always_comb begin
        case (aluop_i)
            OP_LB:   read_data_o = {{24{rd_byte[7]}}, rd_byte};
            OP_LBU:  read_data_o = {24'h000000, rd_byte};
            OP_LH:   read_data_o = {{16{rd_half[15]}}, rd_half};
            OP_LHU:  read_data_o = {16'h0000, rd_half};
            OP_LW:   read_data_o = ram_rdata_i;
            default: read_data_o = '0;
        endcase
    end

    assign ram_ce_o = ~rst_i & (rmem_i | wmem_i);
    assign ram_we_o = ~rst_i & wmem_i;

endmodule

// File: source/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [mem_pkg::DOUBLE_W-1:0] wdata_i,
    input  logic                         mt_hi_i,
    input  logic                         mt_lo_i,
    input  logic                         rmem_i,
    input  logic                         wmem_i,
    input  mem_pkg::aluop_t              aluop_i,
    input  logic [31:0]                  mem_io_addr_i,
    input  logic [31:0]                  exc_flags_i,
    input  logic [mem_pkg::DATA_W-1:0]   cp0_status_i,
    input  logic [mem_pkg::DATA_W-1:0]   cp0_cause_i,
    input  logic [mem_pkg::DATA_W-1:0]   cp0_epc_i,
    input  logic                         wb_cp0_we_i,
    input  logic [4:0]                   wb_cp0_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]   wb_cp0_data_i,
    input  logic [mem_pkg::DATA_W-1:0]   ram_rdata_i,
    output logic [mem_pkg::DOUBLE_W-1:0] wdata_o,
    output logic [mem_pkg::DATA_W-1:0]   hi_o,
    output logic [mem_pkg::DATA_W-1:0]   lo_o,
    output logic [31:0]                  exception_type_o,
    output logic [mem_pkg::DATA_W-1:0]   cp0_epc_o,
    output logic [31:0]                  ram_addr_o,
    output logic [3:0]                   ram_sel_o,
    output logic [mem_pkg::DATA_W-1:0]   ram_wdata_o,
    output logic                         ram_we_o,
    output logic                         ram_ce_o
);

    import mem_pkg::*;

    logic [DATA_W-1:0] status_newest;
    logic [DATA_W-1:0] cause_newest;
    logic [DATA_W-1:0] epc_newest;
    logic [DATA_W-1:0] read_data;
    logic              wmem_gated;
    logic              is_load;

    // cp0 values, write-back stage wins
    always_comb begin
        status_newest = cp0_status_i;
        cause_newest  = cp0_cause_i;
        epc_newest    = cp0_epc_i;
        if (rst_i) begin
            status_newest = '0;
            cause_newest  = '0;
            epc_newest    = '0;
        end else if (wb_cp0_we_i) begin
            if (wb_cp0_addr_i == CP0_REG_STATUS) begin
                status_newest = wb_cp0_data_i;
            end
            if (wb_cp0_addr_i == CP0_REG_CAUSE) begin
                cause_newest[23:22] = wb_cp0_data_i[23:22];   // only IV/WP and soft IP
                cause_newest[9:8]   = wb_cp0_data_i[9:8];
            end
            if (wb_cp0_addr_i == CP0_REG_EPC) begin
                epc_newest = wb_cp0_data_i;
            end
        end
    end

    assign cp0_epc_o = epc_newest;

    exception_detect exception_detect_i (
        .rst_i            (rst_i),
        .exc_flags_i      (exc_flags_i),
        .cp0_status_i     (status_newest),
        .cp0_cause_i      (cause_newest),
        .exception_type_o (exception_type_o)
    );

    hilo_reg hilo_reg_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .new_hi_i (wdata_i[DOUBLE_W-1:DATA_W]),
        .w_hi_i   (mt_hi_i),
        .new_lo_i (wdata_i[DATA_W-1:0]),
        .w_lo_i   (mt_lo_i),
        .hi_o     (hi_o),
        .lo_o     (lo_o)
    );

    assign wmem_gated = wmem_i & ~(|exception_type_o);   // drop store on exception

    mem_io_controller mem_io_controller_i (
        .rst_i         (rst_i),
        .aluop_i       (aluop_i),
        .store_data_i  (wdata_i[DATA_W-1:0]),
        .mem_io_addr_i (mem_io_addr_i),
        .rmem_i        (rmem_i),
        .wmem_i        (wmem_gated),
        .ram_rdata_i   (ram_rdata_i),
        .ram_addr_o    (ram_addr_o),
        .ram_sel_o     (ram_sel_o),
        .ram_wdata_o   (ram_wdata_o),
        .ram_we_o      (ram_we_o),
        .ram_ce_o      (ram_ce_o),
        .read_data_o   (read_data)
    );

    assign is_load = aluop_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign wdata_o = is_load ? {read_data, read_data} : wdata_i;

endmodule

// File: source/data_ram.sv
`timescale 1ns/10ps

module data_ram (
    input  logic                       clk_i,
    input  logic                       ce_i,
    input  logic                       we_i,
    input  logic [31:0]                addr_i,
    input  logic [3:0]                 sel_i,
    input  logic [mem_pkg::DATA_W-1:0] wdata_i,
    output logic [mem_pkg::DATA_W-1:0] rdata_o
);

    import mem_pkg::*;

    localparam int DEPTH = 2 ** RAM_DEPTH_LOG2;

    logic [DATA_W-1:0]         mem [DEPTH];
    logic [RAM_DEPTH_LOG2-1:0] word_idx;

    assign word_idx = addr_i[RAM_DEPTH_LOG2+1:2];   // byte address to word

    // byte lane writes
    always_ff @(posedge clk_i) begin
        if (ce_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = ce_i ? mem[word_idx] : '0;

endmodule

// File: source/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [mem_pkg::DOUBLE_W-1:0] wdata_i,
    input  logic                         mt_hi_i,
    input  logic                         mt_lo_i,
    input  logic                         rmem_i,
    input  logic                         wmem_i,
    input  mem_pkg::aluop_t              aluop_i,
    input  logic [31:0]                  mem_io_addr_i,
    input  logic [31:0]                  exc_flags_i,
    input  logic [mem_pkg::DATA_W-1:0]   cp0_status_i,
    input  logic [mem_pkg::DATA_W-1:0]   cp0_cause_i,
    input  logic [mem_pkg::DATA_W-1:0]   cp0_epc_i,
    input  logic                         wb_cp0_we_i,
    input  logic [4:0]                   wb_cp0_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]   wb_cp0_data_i,
    output logic [mem_pkg::DOUBLE_W-1:0] wdata_o,
    output logic [mem_pkg::DATA_W-1:0]   hi_o,
    output logic [mem_pkg::DATA_W-1:0]   lo_o,
    output logic [31:0]                  exception_type_o,
    output logic [mem_pkg::DATA_W-1:0]   cp0_epc_o
);

    import mem_pkg::*;

    logic [31:0]       ram_addr;
    logic [3:0]        ram_sel;
    logic [DATA_W-1:0] ram_wdata;
    logic [DATA_W-1:0] ram_rdata;
    logic              ram_we;
    logic              ram_ce;

    mem_stage mem_stage_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .wdata_i          (wdata_i),
        .mt_hi_i          (mt_hi_i),
        .mt_lo_i          (mt_lo_i),
        .rmem_i           (rmem_i),
        .wmem_i           (wmem_i),
        .aluop_i          (aluop_i),
        .mem_io_addr_i    (mem_io_addr_i),
        .exc_flags_i      (exc_flags_i),
        .cp0_status_i     (cp0_status_i),
        .cp0_cause_i      (cp0_cause_i),
        .cp0_epc_i        (cp0_epc_i),
        .wb_cp0_we_i      (wb_cp0_we_i),
        .wb_cp0_addr_i    (wb_cp0_addr_i),
        .wb_cp0_data_i    (wb_cp0_data_i),
        .ram_rdata_i      (ram_rdata),
        .wdata_o          (wdata_o),
        .hi_o             (hi_o),
        .lo_o             (lo_o),
        .exception_type_o (exception_type_o),
        .cp0_epc_o        (cp0_epc_o),
        .ram_addr_o       (ram_addr),
        .ram_sel_o        (ram_sel),
        .ram_wdata_o      (ram_wdata),
        .ram_we_o         (ram_we),
        .ram_ce_o         (ram_ce)
    );

    data_ram data_ram_i (
        .clk_i   (clk_i),
        .ce_i    (ram_ce),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .sel_i   (ram_sel),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: tb/tb_mem_checks.svh
`ifndef TB_MEM_CHECKS_SVH
`define TB_MEM_CHECKS_SVH

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
        stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
endtask

task automatic check_double(input string name, input logic [DOUBLE_W-1:0] got,
                            input logic [DOUBLE_W-1:0] exp);
    if (got !== exp) begin
        stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
endtask

task automatic check_exc(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        stop_run($sformatf("Mismatch exception_type_o: got %h, expected %h", got, exp));
    end
endtask

// lane 0 is the most significant byte
function automatic logic [7:0] lane_byte(input logic [31:0] w, input int k);
    return w[31 - 8*k -: 8];
endfunction

function automatic logic [31:0] load_ref(input aluop_t op, input logic [31:0] w,
                                         input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = lane_byte(w, off);
    h = {lane_byte(w, {off[1], 1'b0}), lane_byte(w, {off[1], 1'b1})};
    case (op)
        OP_LB:   return {{24{b[7]}}, b};
        OP_LBU:  return {24'h000000, b};
        OP_LH:   return {{16{h[15]}}, h};
        OP_LHU:  return {16'h0000, h};
        default: return w;
    endcase
endfunction

function automatic logic [31:0] store_ref(input aluop_t op, input logic [31:0] old,
                                          input logic [31:0] d, input logic [1:0] off);
    logic [31:0] w;
    w = old;
    case (op)
        OP_SB:   w[31 - 8*off -: 8] = d[7:0];
        OP_SH:   w[31 - 16*off[1] -: 16] = d[15:0];
        default: w = d;
    endcase
    return w;
endfunction

function automatic logic [31:0] exc_ref(input logic [31:0] flags, input logic [31:0] status,
                                        input logic [31:0] cause);
    if ((|(cause[15:8] & status[15:8])) && status[0] && !status[1]) return EXC_INT;
    if (flags[EXC_FLAG_SYSCALL]) return EXC_SYSCALL;
    if (flags[EXC_FLAG_INV]) return EXC_INV;
    if (flags[EXC_FLAG_TRAP]) return EXC_TRAP;
    if (flags[EXC_FLAG_OV]) return EXC_OV;
    if (flags[EXC_FLAG_ERET]) return EXC_ERET;
    return EXC_NONE;
endfunction

`endif

// File: tb/tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem;

    import mem_pkg::*;

    localparam time CLK_PERIOD     = 100ns;
    localparam int  TEST_CYCLES    = 200;               // rough length of all tests
    localparam int  TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                clk_i;
    logic                rst_i;
    logic [DOUBLE_W-1:0] wdata_i;
    logic                mt_hi_i;
    logic                mt_lo_i;
    logic                rmem_i;
    logic                wmem_i;
    aluop_t              aluop_i;
    logic [31:0]         mem_io_addr_i;
    logic [31:0]         exc_flags_i;
    logic [DATA_W-1:0]   cp0_status_i;
    logic [DATA_W-1:0]   cp0_cause_i;
    logic [DATA_W-1:0]   cp0_epc_i;
    logic                wb_cp0_we_i;
    logic [4:0]          wb_cp0_addr_i;
    logic [DATA_W-1:0]   wb_cp0_data_i;
    logic [DOUBLE_W-1:0] wdata_o;
    logic [DATA_W-1:0]   hi_o;
    logic [DATA_W-1:0]   lo_o;
    logic [31:0]         exception_type_o;
    logic [DATA_W-1:0]   cp0_epc_o;

    logic [31:0] rng_state = 32'h793e;
    logic [31:0] shadow_mem [2**RAM_DEPTH_LOG2];   // expected ram words
    int          cycle_cnt = 0;

    mem_subsystem mem_subsystem_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_mem_checks.svh"

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // drive one op on the edge, return at mid cycle
    task automatic issue(input logic rd, input logic wr, input aluop_t op,
                         input logic [31:0] addr, input logic [DOUBLE_W-1:0] data);
        @(posedge clk_i);
        rmem_i        <= rd;
        wmem_i        <= wr;
        aluop_i       <= op;
        mem_io_addr_i <= addr;
        wdata_i       <= data;
        @(negedge clk_i);
    endtask

    task automatic store(input aluop_t op, input logic [31:0] addr, input logic [31:0] data);
        issue(1'b0, 1'b1, op, addr, {next_random(), data});
        shadow_mem[addr[RAM_DEPTH_LOG2+1:2]] =
            store_ref(op, shadow_mem[addr[RAM_DEPTH_LOG2+1:2]], data, addr[1:0]);
    endtask

    task automatic load_check(input aluop_t op, input logic [31:0] addr);
        logic [31:0] expected;
        expected = load_ref(op, shadow_mem[addr[RAM_DEPTH_LOG2+1:2]], addr[1:0]);
        issue(1'b1, 1'b0, op, addr, {next_random(), next_random()});
        check_double("wdata_o", wdata_o, {expected, expected});
    endtask

    task automatic exc_case(input logic [31:0] flags, input logic [31:0] status,
                            input logic [31:0] cause);
        @(posedge clk_i);
        exc_flags_i  <= flags;
        cp0_status_i <= status;
        cp0_cause_i  <= cause;
        @(negedge clk_i);
        check_exc(exception_type_o, exc_ref(flags, status, cause));
    endtask

    task automatic reset_values();
        @(posedge clk_i);
        @(negedge clk_i);
        check_exc(exception_type_o, EXC_NONE);   // flags are up but reset wins
        check_word("cp0_epc_o", cp0_epc_o, '0);
        @(posedge clk_i);
        rst_i       <= 1'b0;
        exc_flags_i <= '0;
        cp0_epc_i   <= '0;
        @(negedge clk_i);
        check_word("hi_o", hi_o, '0);
        check_word("lo_o", lo_o, '0);
        check_word("cp0_epc_o", cp0_epc_o, '0);
        check_exc(exception_type_o, EXC_NONE);
    endtask

    task automatic word_traffic();
        logic [31:0]         addrs [32];
        logic [DOUBLE_W-1:0] data;
        for (int i = 0; i < 32; i++) begin
            addrs[i] = next_random() & ~32'h3;
            store(OP_SW, addrs[i], next_random());
        end
        for (int i = 0; i < 32; i++) begin
            load_check(OP_LW, addrs[i]);
        end
        data = {next_random(), next_random()};
        issue(1'b0, 1'b0, OP_NOP, next_random(), data);
        check_double("wdata_o", wdata_o, data);   // plain pass-through
    endtask

    task automatic narrow_traffic();
        logic [31:0] base;
        repeat (3) begin
            base = next_random() & ~32'h3;
            store(OP_SW, base, next_random());
            for (int off = 0; off < 4; off++) begin
                store(OP_SB, base + off, next_random());
            end
            for (int off = 0; off < 4; off++) begin
                load_check(OP_LB, base + off);
                load_check(OP_LBU, base + off);
            end
            for (int off = 0; off < 4; off += 2) begin
                store(OP_SH, base + off, next_random());
                load_check(OP_LH, base + off);
                load_check(OP_LHU, base + off);
            end
            load_check(OP_LW, base);
        end
    endtask

    task automatic hilo_updates();
        logic [DOUBLE_W-1:0] data;
        logic [31:0]         hi_exp;
        logic [31:0]         lo_exp;
        issue(1'b0, 1'b0, OP_NOP, '0, '0);
        hi_exp = '0;   // no strobe since reset
        lo_exp = '0;
        for (int k = 1; k < 4; k++) begin   // lo only, hi only, both
            data = {next_random(), next_random()};
            @(posedge clk_i);
            mt_hi_i <= k[1];
            mt_lo_i <= k[0];
            wdata_i <= data;
            @(posedge clk_i);
            mt_hi_i <= 1'b0;
            mt_lo_i <= 1'b0;
            @(negedge clk_i);
            if (k[1]) hi_exp = data[63:32];
            if (k[0]) lo_exp = data[31:0];
            check_word("hi_o", hi_o, hi_exp);
            check_word("lo_o", lo_o, lo_exp);
        end
    endtask

    task automatic exception_priority();
        int          flag_pos [5];
        logic [31:0] addr;
        logic [31:0] word;
        flag_pos = '{EXC_FLAG_SYSCALL, EXC_FLAG_INV, EXC_FLAG_TRAP, EXC_FLAG_OV, EXC_FLAG_ERET};
        foreach (flag_pos[i]) begin
            exc_case(32'h1 << flag_pos[i], '0, '0);
        end
        exc_case(32'h0000_1f00, '0, '0);
        exc_case(32'h0000_1c00, '0, '0);
        exc_case(32'h0000_1200, '0, '0);
        exc_case(32'h0000_1800, '0, '0);
        exc_case(32'h0000_1f00, 32'h0000_0401, 32'h0000_0400);   // ip2 enabled
        exc_case('0, 32'h0000_0801, 32'h0000_0400);             // masked
        exc_case('0, 32'h0000_0403, 32'h0000_0400);             // exl set
        exc_case('0, '0, '0);
        addr = next_random() & ~32'h3;
        word = next_random();
        store(OP_SW, addr, word);
        @(posedge clk_i);
        exc_flags_i <= 32'h1 << EXC_FLAG_TRAP;
        wdata_i     <= {2{~word}};   // this store must be dropped
        @(negedge clk_i);
        check_exc(exception_type_o, EXC_TRAP);
        @(posedge clk_i);
        exc_flags_i <= '0;
        wmem_i      <= 1'b0;
        load_check(OP_LW, addr);
    endtask

    task automatic cp0_forwarding();
        logic [31:0] epc_rf;
        logic [31:0] epc_wb;
        epc_rf = next_random();
        epc_wb = next_random();
        @(posedge clk_i);
        cp0_epc_i     <= epc_rf;
        wb_cp0_we_i   <= 1'b1;
        wb_cp0_addr_i <= CP0_REG_EPC;
        wb_cp0_data_i <= epc_wb;
        @(negedge clk_i);
        check_word("cp0_epc_o", cp0_epc_o, epc_wb);
        @(posedge clk_i);
        wb_cp0_addr_i <= CP0_REG_STATUS;
        @(negedge clk_i);
        check_word("cp0_epc_o", cp0_epc_o, epc_rf);
        @(posedge clk_i);
        wb_cp0_we_i   <= 1'b0;
        wb_cp0_addr_i <= CP0_REG_EPC;
        @(negedge clk_i);
        check_word("cp0_epc_o", cp0_epc_o, epc_rf);
        // soft interrupt line 1 arrives through the write-back path
        @(posedge clk_i);
        cp0_status_i  <= 32'h0000_0201;
        cp0_cause_i   <= '0;
        wb_cp0_we_i   <= 1'b1;
        wb_cp0_addr_i <= CP0_REG_CAUSE;
        wb_cp0_data_i <= 32'h0000_0200;
        @(negedge clk_i);
        check_exc(exception_type_o, EXC_INT);
        @(posedge clk_i);
        wb_cp0_we_i <= 1'b0;
        @(negedge clk_i);
        check_exc(exception_type_o, EXC_NONE);
    endtask

    initial begin
        rst_i         = 1'b1;
        wdata_i       = '0;
        mt_hi_i       = 1'b0;
        mt_lo_i       = 1'b0;
        rmem_i        = 1'b0;
        wmem_i        = 1'b0;
        aluop_i       = OP_NOP;
        mem_io_addr_i = '0;
        cp0_status_i  = '0;
        cp0_cause_i   = '0;
        wb_cp0_we_i   = 1'b0;
        wb_cp0_addr_i = '0;
        wb_cp0_data_i = '0;
        cp0_epc_i     = 32'h5a5a_0004;   // hidden during reset
        exc_flags_i   = 32'h1 << EXC_FLAG_SYSCALL;
        reset_values();
        word_traffic();
        narrow_traffic();
        hilo_updates();
        exception_priority();
        cp0_forwarding();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: build.f
+incdir+tb
source/mem_pkg.sv
source/exception_detect.sv
source/hilo_reg.sv
source/mem_io_controller.sv
source/mem_stage.sv
source/data_ram.sv
source/mem_subsystem.sv
tb/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - source/mem_pkg.sv
  - source/exception_detect.sv
  - source/hilo_reg.sv
  - source/mem_io_controller.sv
  - source/mem_stage.sv
  - source/data_ram.sv
  - source/mem_subsystem.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mem_subsystem.sv
